//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ****************************************
// core dimensions
// ****************************************

`define XLEN_W      32
`define REG_COUNT   32
`define IMEM_DEPTH  1024

// word address into data memory
`define DADDR_W     20

// ****************************************
// special registers
// ****************************************

// return address of jal
`define LINK_REG    28

// stack pointer and its start value
`define STACK_REG   27
`define STACK_INIT  32'd32768

`endif

//--- cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`XLEN_W-1:0]             word_t;
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] pc_t;
    typedef logic [$clog2(`REG_COUNT)-1:0]  reg_idx_t;
    typedef logic [`DADDR_W-1:0]            daddr_t;

    // ****************************************
    // instruction encodings
    // ****************************************

    // major opcode, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_bl      = 6'b000001,
        op_j       = 6'b000010,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_bg      = 6'b000110,
        op_addi    = 6'b001000,
        op_bge     = 6'b001001,
        op_ble     = 6'b001011,
        op_jal     = 6'b011000,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_t;

    // funct field of special, bits 5:0
    // ret is the all-zero word
    typedef enum logic [5:0] {
        fn_ret  = 6'b000000,
        fn_jr   = 6'b001000,
        fn_mov  = 6'b001001,
        fn_mult = 6'b011001,
        fn_div  = 6'b011010,
        fn_add  = 6'b100000,
        fn_sub  = 6'b100010
    } funct_t;

    // operation carried from decode to execute
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_mul,
        alu_div,
        alu_pass,
        alu_link
    } alu_op_t;

endpackage

//--- instr_mem.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module instr_mem (
    input  logic             clk,
    input  logic             imem_we,
    input  cpu_pkg::pc_t     imem_addr,
    input  cpu_pkg::word_t   imem_wdata,
    input  cpu_pkg::pc_t     fetch_pc,
    output cpu_pkg::word_t   fetch_word
);

    cpu_pkg::word_t mem [`IMEM_DEPTH];

    // load port, driven by the environment while the core is in reset
    always_ff @(posedge clk) begin
        if (imem_we) begin
            mem[imem_addr] <= imem_wdata;
        end
    end

    // fetch sees the word in the same cycle
    assign fetch_word = mem[fetch_pc];

endmodule

//--- fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
    input  logic                clk,
    input  logic                rstn,
    input  cpu_pkg::word_t      fetch_word,
    output cpu_pkg::pc_t        fetch_pc,
    input  logic                stall,
    input  logic                flush,
    input  cpu_pkg::pc_t        redirect_pc,
    input  logic                halt_req,
    input  cpu_pkg::word_t      jr_data,
    input  logic                jr_busy,
    output cpu_pkg::reg_idx_t   jr_idx,
    output logic                fd_valid,
    output cpu_pkg::word_t      fd_instr,
    output cpu_pkg::pc_t        fd_pc,
    output logic                halted
);

    cpu_pkg::pc_t    pc;
    cpu_pkg::pc_t    next_pc;
    cpu_pkg::opcode_t op;
    logic            is_jr;
    logic            jr_wait;

    assign op       = cpu_pkg::opcode_t'(fetch_word[31:26]);
    assign jr_idx   = fetch_word[25:21];
    assign fetch_pc = pc;

    assign is_jr = (op == cpu_pkg::op_special) &&
                   (cpu_pkg::funct_t'(fetch_word[5:0]) == cpu_pkg::fn_jr);

    // the instruction still in decode has not marked its destination yet,
    // so jr also waits for it to issue
    assign jr_wait = is_jr && (jr_busy || fd_valid);

    // ****************************************
    // next pc, branches predicted taken
    // ****************************************
    always_comb begin
        next_pc = pc + 1'b1;
        case (op)
            cpu_pkg::op_special: begin
                if (is_jr) begin
                    next_pc = cpu_pkg::pc_t'(jr_data);
                end
            end
            cpu_pkg::op_j, cpu_pkg::op_jal: begin
                next_pc = cpu_pkg::pc_t'(fetch_word);
            end
            // low offset bits are enough, the pc wraps
            cpu_pkg::op_beq, cpu_pkg::op_bne, cpu_pkg::op_bl,
            cpu_pkg::op_ble, cpu_pkg::op_bg, cpu_pkg::op_bge: begin
                next_pc = pc + cpu_pkg::pc_t'(fetch_word);
            end
            default: begin
                next_pc = pc + 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc       <= '0;
            fd_valid <= 1'b0;
            halted   <= 1'b0;
        end else if (!halted) begin
            if (halt_req) begin
                halted   <= 1'b1;
                fd_valid <= 1'b0;
            end else if (flush) begin
                pc       <= redirect_pc;
                fd_valid <= 1'b0;
            end else if (!stall) begin
                if (jr_wait) begin
                    // bubble until the jr register is written
                    fd_valid <= 1'b0;
                end else begin
                    fd_valid <= 1'b1;
                    fd_instr <= fetch_word;
                    fd_pc    <= pc;
                    pc       <= next_pc;
                end
            end
        end
    end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                rstn,
    input  cpu_pkg::reg_idx_t   ra_idx,
    input  cpu_pkg::reg_idx_t   rb_idx,
    input  cpu_pkg::reg_idx_t   rc_idx,
    output cpu_pkg::word_t      ra_data,
    output cpu_pkg::word_t      rb_data,
    output cpu_pkg::word_t      rc_data,
    output logic                ra_busy,
    output logic                rb_busy,
    output logic                rc_busy,
    input  logic                set_busy,
    input  cpu_pkg::reg_idx_t   set_idx,
    input  logic                wb_en,
    input  cpu_pkg::reg_idx_t   wb_idx,
    input  cpu_pkg::word_t      wb_data
);

    cpu_pkg::word_t           regs [`REG_COUNT];
    logic [`REG_COUNT-1:0]    busy;

    // ****************************************
    // read ports
    // ****************************************
    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];
    assign rc_data = regs[rc_idx];

    assign ra_busy = busy[ra_idx];
    assign rb_busy = busy[rb_idx];
    assign rc_busy = busy[rc_idx];

    // ****************************************
    // write port and scoreboard
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            regs[`STACK_REG] <= `STACK_INIT;
            busy             <= '0;
        end else begin
            // register 0 is an ordinary register here
            if (wb_en) begin
                regs[wb_idx] <= wb_data;
                busy[wb_idx] <= 1'b0;
            end
            // a new writer issued in the same cycle keeps its bit set
            if (set_busy) begin
                busy[set_idx] <= 1'b1;
            end
        end
    end

endmodule

//--- decode_unit.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module decode_unit (
    input  logic                clk,
    input  logic                rstn,
    input  logic                fd_valid,
    input  cpu_pkg::word_t      fd_instr,
    input  cpu_pkg::pc_t        fd_pc,
    output cpu_pkg::reg_idx_t   ra_idx,
    output cpu_pkg::reg_idx_t   rb_idx,
    input  cpu_pkg::word_t      ra_data,
    input  cpu_pkg::word_t      rb_data,
    input  logic                ra_busy,
    input  logic                rb_busy,
    output logic                stall,
    input  logic                flush,
    output logic                set_busy,
    output cpu_pkg::reg_idx_t   set_idx,
    output logic                de_valid,
    output cpu_pkg::opcode_t    de_op,
    output cpu_pkg::alu_op_t    de_alu_op,
    output cpu_pkg::word_t      de_a,
    output cpu_pkg::word_t      de_b,
    output cpu_pkg::word_t      de_imm,
    output cpu_pkg::reg_idx_t   de_dest,
    output logic                de_writes,
    output cpu_pkg::pc_t        de_pc
);

    cpu_pkg::opcode_t   op;
    cpu_pkg::funct_t    funct;
    cpu_pkg::reg_idx_t  rd;
    cpu_pkg::reg_idx_t  dest;
    cpu_pkg::alu_op_t   alu_op;
    cpu_pkg::word_t     imm;
    logic               reads_a;
    logic               reads_b;
    logic               writes;
    logic               waw;
    logic               issue;

    // ****************************************
    // field extraction
    // ****************************************
    assign op     = cpu_pkg::opcode_t'(fd_instr[31:26]);
    assign funct  = cpu_pkg::funct_t'(fd_instr[5:0]);
    assign ra_idx = fd_instr[25:21];
    assign rb_idx = fd_instr[20:16];
    assign rd     = fd_instr[15:11];
    assign imm    = {{16{fd_instr[15]}}, fd_instr[15:0]};

    always_comb begin
        reads_a = 1'b0;
        reads_b = 1'b0;
        writes  = 1'b0;
        dest    = rd;
        alu_op  = cpu_pkg::alu_add;
        case (op)
            cpu_pkg::op_special: begin
                case (funct)
                    cpu_pkg::fn_add, cpu_pkg::fn_sub,
                    cpu_pkg::fn_mult, cpu_pkg::fn_div: begin
                        reads_a = 1'b1;
                        reads_b = 1'b1;
                        writes  = 1'b1;
                        if (funct == cpu_pkg::fn_sub) begin
                            alu_op = cpu_pkg::alu_sub;
                        end else if (funct == cpu_pkg::fn_mult) begin
                            alu_op = cpu_pkg::alu_mul;
                        end else if (funct == cpu_pkg::fn_div) begin
                            alu_op = cpu_pkg::alu_div;
                        end
                    end
                    cpu_pkg::fn_mov: begin
                        reads_a = 1'b1;
                        writes  = 1'b1;
                        alu_op  = cpu_pkg::alu_pass;
                    end
                    // jr is done in fetch, ret in execute
                    default: ;
                endcase
            end
            cpu_pkg::op_addi, cpu_pkg::op_lw: begin
                reads_a = 1'b1;
                writes  = 1'b1;
                dest    = rb_idx;
            end
            cpu_pkg::op_sw: begin
                reads_a = 1'b1;
                reads_b = 1'b1;
            end
            cpu_pkg::op_jal: begin
                writes = 1'b1;
                dest   = cpu_pkg::reg_idx_t'(`LINK_REG);
                alu_op = cpu_pkg::alu_link;
            end
            cpu_pkg::op_beq, cpu_pkg::op_bne, cpu_pkg::op_bl,
            cpu_pkg::op_ble, cpu_pkg::op_bg, cpu_pkg::op_bge: begin
                reads_a = 1'b1;
                reads_b = 1'b1;
                alu_op  = cpu_pkg::alu_sub;
            end
            default: ;
        endcase
    end

    // ****************************************
    // hazards and issue
    // ****************************************

    // the writer now in execute clears its busy bit one cycle too late
    // for a second writer of the same register, so hold that one back
    assign waw   = writes && de_valid && de_writes && (de_dest == dest);
    assign stall = fd_valid && ((reads_a && ra_busy) || (reads_b && rb_busy) || waw);
    assign issue = fd_valid && !stall && !flush;

    assign set_busy = issue && writes;
    assign set_idx  = dest;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            de_op     <= op;
            de_alu_op <= alu_op;
            de_a      <= ra_data;
            de_b      <= rb_data;
            de_imm    <= imm;
            de_dest   <= dest;
            de_writes <= writes;
            de_pc     <= fd_pc;
        end
    end

endmodule

//--- execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  logic                clk,
    input  logic                rstn,
    input  logic                de_valid,
    input  cpu_pkg::opcode_t    de_op,
    input  cpu_pkg::alu_op_t    de_alu_op,
    input  cpu_pkg::word_t      de_a,
    input  cpu_pkg::word_t      de_b,
    input  cpu_pkg::word_t      de_imm,
    input  cpu_pkg::reg_idx_t   de_dest,
    input  logic                de_writes,
    input  cpu_pkg::pc_t        de_pc,
    input  cpu_pkg::word_t      read_data,
    output cpu_pkg::daddr_t     memory_addr,
    output logic                we,
    output cpu_pkg::word_t      write_data,
    output logic                flush,
    output cpu_pkg::pc_t        redirect_pc,
    output logic                halt_req,
    output logic                wb_en,
    output cpu_pkg::reg_idx_t   wb_idx,
    output cpu_pkg::word_t      wb_data
);

    localparam int DADDR_BITS = $bits(cpu_pkg::daddr_t);

    cpu_pkg::word_t  op_b;
    cpu_pkg::word_t  alu_result;
    cpu_pkg::word_t  addr_sum;
    logic            is_branch;
    logic            taken;
    logic            is_ret;

    // ****************************************
    // ALU
    // ****************************************

    // register operand for special, immediate otherwise
    assign op_b = (de_op == cpu_pkg::op_special) ? de_b : de_imm;

    always_comb begin
        case (de_alu_op)
            cpu_pkg::alu_add:  alu_result = de_a + op_b;
            cpu_pkg::alu_sub:  alu_result = de_a - op_b;
            cpu_pkg::alu_mul:  alu_result = de_a * op_b;
            // unsigned quotient, all ones on a zero divisor
            cpu_pkg::alu_div:  alu_result = (op_b == '0) ? '1 : de_a / op_b;
            cpu_pkg::alu_pass: alu_result = de_a;
            // return address is the word after jal
            cpu_pkg::alu_link: alu_result = cpu_pkg::word_t'(de_pc) + 32'd1;
            default:           alu_result = de_a;
        endcase
    end

    // ****************************************
    // branch resolution
    // ****************************************
    always_comb begin
        is_branch = 1'b1;
        case (de_op)
            cpu_pkg::op_beq: taken = (de_a == de_b);
            cpu_pkg::op_bne: taken = (de_a != de_b);
            cpu_pkg::op_bl:  taken = ($signed(de_a) <  $signed(de_b));
            cpu_pkg::op_ble: taken = ($signed(de_a) <= $signed(de_b));
            cpu_pkg::op_bg:  taken = ($signed(de_a) >  $signed(de_b));
            cpu_pkg::op_bge: taken = ($signed(de_a) >= $signed(de_b));
            default: begin
                is_branch = 1'b0;
                taken     = 1'b1;
            end
        endcase
    end

    // funct of special travels in the low immediate bits
    assign is_ret = de_valid && (de_op == cpu_pkg::op_special) &&
                    (cpu_pkg::funct_t'(de_imm[5:0]) == cpu_pkg::fn_ret);

    // fetch guessed taken, so only a not-taken branch redirects.
    // ret squashes the younger instructions as well
    assign flush       = (de_valid && is_branch && !taken) || is_ret;
    assign redirect_pc = de_pc + 1'b1;
    assign halt_req    = is_ret;

    // ****************************************
    // data memory
    // ****************************************
    assign addr_sum    = de_a + de_imm;
    assign memory_addr = addr_sum[DADDR_BITS+1:2];
    assign we          = de_valid && (de_op == cpu_pkg::op_sw);
    assign write_data  = de_b;

    // ****************************************
    // writeback register
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= de_valid && de_writes;
        end
    end

    always_ff @(posedge clk) begin
        wb_idx  <= de_dest;
        wb_data <= (de_op == cpu_pkg::op_lw) ? read_data : alu_result;
    end

endmodule

//--- cpu_core_top.sv
`timescale 1ns/10ps

module cpu_core_top (
    input  logic              clk,
    input  logic              rstn,
    input  logic              imem_we,
    input  cpu_pkg::pc_t      imem_addr,
    input  cpu_pkg::word_t    imem_wdata,
    input  cpu_pkg::word_t    read_data,
    output cpu_pkg::daddr_t   memory_addr,
    output logic              we,
    output cpu_pkg::word_t    write_data,
    output logic              halted
);

    // fetch side
    cpu_pkg::pc_t       fetch_pc;
    cpu_pkg::word_t     fetch_word;
    cpu_pkg::reg_idx_t  jr_idx;
    cpu_pkg::word_t     jr_data;
    logic               jr_busy;

    // F/D
    logic               fd_valid;
    cpu_pkg::word_t     fd_instr;
    cpu_pkg::pc_t       fd_pc;
    logic               stall;

    // register file ports of decode
    cpu_pkg::reg_idx_t  ra_idx;
    cpu_pkg::reg_idx_t  rb_idx;
    cpu_pkg::word_t     ra_data;
    cpu_pkg::word_t     rb_data;
    logic               ra_busy;
    logic               rb_busy;
    logic               set_busy;
    cpu_pkg::reg_idx_t  set_idx;

    // D/E
    logic               de_valid;
    cpu_pkg::opcode_t   de_op;
    cpu_pkg::alu_op_t   de_alu_op;
    cpu_pkg::word_t     de_a;
    cpu_pkg::word_t     de_b;
    cpu_pkg::word_t     de_imm;
    cpu_pkg::reg_idx_t  de_dest;
    logic               de_writes;
    cpu_pkg::pc_t       de_pc;

    // E/W and redirects
    logic               wb_en;
    cpu_pkg::reg_idx_t  wb_idx;
    cpu_pkg::word_t     wb_data;
    logic               flush;
    cpu_pkg::pc_t       redirect_pc;
    logic               halt_req;

    instr_mem i_imem (.*);

    fetch_unit i_fetch (.*);

    reg_file i_regs (
        .clk, .rstn,
        .ra_idx, .rb_idx, .rc_idx (jr_idx),
        .ra_data, .rb_data, .rc_data (jr_data),
        .ra_busy, .rb_busy, .rc_busy (jr_busy),
        .set_busy, .set_idx,
        .wb_en, .wb_idx, .wb_data
    );

    decode_unit i_decode (.*);

    execute_unit i_execute (.*);

endmodule

//--- cpu_checker.sv
`timescale 1ns/10ps

module cpu_checker (
    input logic clk,
    input logic rstn,
    input logic we,
    input logic halted,
    input logic flush
);

    // ****************************************
    // core level properties
    // ****************************************

    // a halted core drives no stores
    no_store_when_halted: assert property (
        @(posedge clk) disable iff (!rstn) !(we && halted)
    ) else $error("store issued while the core is halted");

    // halted only clears through reset
    halted_sticky: assert property (
        @(posedge clk) ($past(halted) && !halted) |-> !$past(rstn)
    ) else $error("halted fell without a reset");

    // the cycle after a flush has a bubble in execute
    single_flush: assert property (
        @(posedge clk) disable iff (!rstn) flush |=> !flush
    ) else $error("flush held high for two cycles");

endmodule

//--- cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_tb;

    localparam int MEM_WORDS = 1 << `DADDR_W;
    localparam int SUB_ADDR  = 200;

    logic              clk = 1'b0;
    logic              rstn = 1'b0;
    logic              imem_we = 1'b0;
    cpu_pkg::pc_t      imem_addr = '0;
    cpu_pkg::word_t    imem_wdata = '0;
    cpu_pkg::word_t    read_data;
    cpu_pkg::daddr_t   memory_addr;
    logic              we;
    cpu_pkg::word_t    write_data;
    logic              halted;

    cpu_pkg::word_t    dmem [MEM_WORDS];
    cpu_pkg::word_t    prog [`IMEM_DEPTH];
    int                plen;

    // stores seen on the bus and stores of the model
    cpu_pkg::daddr_t   got_addr [$];
    cpu_pkg::word_t    got_data [$];
    cpu_pkg::daddr_t   exp_addr [$];
    cpu_pkg::word_t    exp_data [$];
    cpu_pkg::word_t    model_mem [cpu_pkg::daddr_t];

    int                errors = 0;
    int                test_errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                cycle_budget = 10;
    int                cycles_used = 0;

    cpu_core_top i_dut (.*);

    bind cpu_core_top cpu_checker i_checker (
        .clk(clk), .rstn(rstn), .we(we), .halted(halted), .flush(flush)
    );

    assign read_data = dmem[memory_addr];

    initial begin
        forever #50 clk = ~clk;
    end

    // ****************************************
    // helpers
    // ****************************************

    function automatic cpu_pkg::word_t fill_word(input cpu_pkg::daddr_t a);
        return {a[11:0], a} ^ 32'h6b43_a9c5;
    endfunction

    // unwritten words keep the memory contents from the start of the test
    function automatic cpu_pkg::word_t model_read(input cpu_pkg::daddr_t a);
        if (model_mem.exists(a)) begin
            return model_mem[a];
        end
        return dmem[a];
    endfunction

    function automatic cpu_pkg::word_t enc_r(input cpu_pkg::funct_t fn, input int rs,
                                             input int rt, input int rd);
        return {cpu_pkg::op_special, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic cpu_pkg::word_t enc_i(input cpu_pkg::opcode_t op, input int rs,
                                             input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic cpu_pkg::word_t enc_j(input cpu_pkg::opcode_t op, input int target);
        return {op, 26'(target)};
    endfunction

    function automatic logic [15:0] rand_imm();
        return 16'($urandom);
    endfunction

    // -2 to 2, so that equal operands show up often
    function automatic logic [15:0] small_imm();
        return 16'($urandom_range(4, 0)) - 16'd2;
    endfunction

    function automatic cpu_pkg::opcode_t branch_op(input int k);
        case (k)
            0: return cpu_pkg::op_beq;
            1: return cpu_pkg::op_bne;
            2: return cpu_pkg::op_bl;
            3: return cpu_pkg::op_ble;
            4: return cpu_pkg::op_bg;
            default: return cpu_pkg::op_bge;
        endcase
    endfunction

    task automatic emit(input cpu_pkg::word_t w);
        prog[plen] = w;
        plen++;
    endtask

    // ****************************************
    // program generators
    // ****************************************

    task automatic new_program();
        plen = 0;
        foreach (prog[i]) begin
            prog[i] = '0;
        end
        for (int r = 1; r <= 8; r++) begin
            emit(enc_i(cpu_pkg::op_addi, 0, r, rand_imm()));
        end
    endtask

    task automatic gen_arith(input int n, input bit chain);
        int rs;
        int rt;
        int rd;
        int last;
        last = 1;
        // r0 stays zero, a divisor of zero
        emit(enc_r(cpu_pkg::fn_div, 1, 0, 9));
        emit(enc_i(cpu_pkg::op_sw, 0, 9, rand_imm()));
        for (int i = 0; i < n; i++) begin
            rs = chain ? last : $urandom_range(8, 1);
            rt = $urandom_range(8, 0);
            rd = $urandom_range(8, 1);
            case ($urandom_range(5, 0))
                0: emit(enc_r(cpu_pkg::fn_add, rs, rt, rd));
                1: emit(enc_r(cpu_pkg::fn_sub, rs, rt, rd));
                2: emit(enc_r(cpu_pkg::fn_mult, rs, rt, rd));
                3: emit(enc_r(cpu_pkg::fn_div, rs, rt, rd));
                4: emit(enc_r(cpu_pkg::fn_mov, rs, 0, rd));
                default: emit(enc_i(cpu_pkg::op_addi, rs, rd, rand_imm()));
            endcase
            if (!chain || (i % 2) == 1) begin
                emit(enc_i(cpu_pkg::op_sw, 0, rd, rand_imm()));
            end
            last = rd;
        end
        emit('0);
    endtask

    task automatic gen_branches(input int n);
        int off;
        int rc;
        for (int r = 1; r <= 6; r++) begin
            emit(enc_i(cpu_pkg::op_addi, 0, r, small_imm()));
        end
        for (int i = 0; i < n; i++) begin
            off = $urandom_range(4, 2);
            emit(enc_i(branch_op($urandom_range(5, 0)), $urandom_range(6, 1),
                       $urandom_range(6, 1), 16'(off)));
            // fall-through words, skipped when taken
            for (int k = 1; k < off; k++) begin
                emit(enc_i(cpu_pkg::op_sw, 0, $urandom_range(8, 1), rand_imm()));
            end
            rc = $urandom_range(6, 1);
            emit(enc_i(cpu_pkg::op_addi, 0, rc, small_imm()));
            emit(enc_i(cpu_pkg::op_sw, 0, rc, rand_imm()));
        end
        emit('0);
    endtask

    task automatic gen_memory(input int n);
        logic [15:0] a_imm;
        int          rd;
        // subroutine past the main program, returns through the link register
        prog[SUB_ADDR]     = enc_i(cpu_pkg::op_addi, 10, 10, rand_imm());
        prog[SUB_ADDR + 1] = enc_i(cpu_pkg::op_sw, 0, 10, rand_imm());
        prog[SUB_ADDR + 2] = enc_r(cpu_pkg::fn_jr, `LINK_REG, 0, 0);
        for (int i = 0; i < n; i++) begin
            a_imm = rand_imm();
            rd    = $urandom_range(9, 7);
            case ($urandom_range(2, 0))
                0: begin
                    emit(enc_i(cpu_pkg::op_sw, 0, $urandom_range(6, 1), a_imm));
                    emit(enc_i(cpu_pkg::op_lw, 0, rd, a_imm));
                    emit(enc_i(cpu_pkg::op_sw, 0, rd, rand_imm()));
                end
                1: begin
                    emit(enc_i(cpu_pkg::op_lw, 0, rd, a_imm));
                    emit(enc_i(cpu_pkg::op_sw, 0, rd, rand_imm()));
                end
                default: begin
                    emit(enc_j(cpu_pkg::op_jal, SUB_ADDR));
                    emit(enc_i(cpu_pkg::op_sw, 0, `LINK_REG, rand_imm()));
                end
            endcase
        end
        emit('0);
        plen = SUB_ADDR + 3;
    endtask

    task automatic gen_halt();
        for (int i = 0; i < 4; i++) begin
            emit(enc_i(cpu_pkg::op_sw, 0, $urandom_range(8, 1), rand_imm()));
        end
        emit('0);
        // squashed behind ret
        for (int i = 0; i < 4; i++) begin
            emit(enc_i(cpu_pkg::op_sw, 0, $urandom_range(8, 1), rand_imm()));
        end
    endtask

    // ****************************************
    // instruction level model
    // ****************************************

    task automatic run_model();
        cpu_pkg::word_t  r [`REG_COUNT];
        cpu_pkg::pc_t    pc;
        cpu_pkg::pc_t    npc;
        cpu_pkg::word_t  w;
        cpu_pkg::word_t  a;
        cpu_pkg::word_t  b;
        cpu_pkg::word_t  imm;
        cpu_pkg::word_t  sum;
        cpu_pkg::daddr_t addr;
        logic            take;
        int              steps;
        exp_addr.delete();
        exp_data.delete();
        model_mem.delete();
        foreach (r[i]) begin
            r[i] = '0;
        end
        r[`STACK_REG] = `STACK_INIT;
        pc    = '0;
        steps = 0;
        while (prog[pc] != '0 && steps < 4000) begin
            w    = prog[pc];
            a    = r[w[25:21]];
            b    = r[w[20:16]];
            imm  = {{16{w[15]}}, w[15:0]};
            sum  = a + imm;
            addr = sum[`DADDR_W+1:2];
            npc  = cpu_pkg::pc_t'(pc + 1);
            take = 1'b0;
            case (w[31:26])
                cpu_pkg::op_special: begin
                    case (w[5:0])
                        cpu_pkg::fn_add:  r[w[15:11]] = a + b;
                        cpu_pkg::fn_sub:  r[w[15:11]] = a - b;
                        cpu_pkg::fn_mult: r[w[15:11]] = a * b;
                        cpu_pkg::fn_div:  r[w[15:11]] = (b == '0) ? '1 : a / b;
                        cpu_pkg::fn_mov:  r[w[15:11]] = a;
                        cpu_pkg::fn_jr:   npc = cpu_pkg::pc_t'(a);
                        default: ;
                    endcase
                end
                cpu_pkg::op_addi: r[w[20:16]] = sum;
                cpu_pkg::op_lw:   r[w[20:16]] = model_read(addr);
                cpu_pkg::op_sw: begin
                    model_mem[addr] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                cpu_pkg::op_j:    npc = cpu_pkg::pc_t'(w[25:0]);
                cpu_pkg::op_jal: begin
                    r[`LINK_REG] = cpu_pkg::word_t'(pc) + 32'd1;
                    npc          = cpu_pkg::pc_t'(w[25:0]);
                end
                cpu_pkg::op_beq:  take = (a == b);
                cpu_pkg::op_bne:  take = (a != b);
                cpu_pkg::op_bl:   take = ($signed(a) < $signed(b));
                cpu_pkg::op_ble:  take = ($signed(a) <= $signed(b));
                cpu_pkg::op_bg:   take = ($signed(a) > $signed(b));
                cpu_pkg::op_bge:  take = ($signed(a) >= $signed(b));
                default: ;
            endcase
            if (take) begin
                npc = cpu_pkg::pc_t'(pc + imm[9:0]);
            end
            pc = npc;
            steps++;
        end
    endtask

    // ****************************************
    // compare tasks
    // ****************************************

    task automatic check_store(input cpu_pkg::daddr_t got_a, input cpu_pkg::word_t got_d,
                               input cpu_pkg::daddr_t exp_a, input cpu_pkg::word_t exp_d);
        checks++;
        if (got_a !== exp_a || got_d !== exp_d) begin
            $display("mismatch at %0t: store %h <- %h, expected %h <- %h",
                     $time, got_a, got_d, exp_a, exp_d);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_word(input cpu_pkg::word_t got, input cpu_pkg::word_t exp,
                              input cpu_pkg::daddr_t where);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: memory word %h is %h, expected %h",
                     $time, where, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // bus monitor and data memory
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = fill_word(cpu_pkg::daddr_t'(i));
        end
        forever begin
            @(negedge clk);
            if (rstn && we) begin
                got_addr.push_back(memory_addr);
                got_data.push_back(write_data);
                dmem[memory_addr] = write_data;
            end
        end
    end

    task automatic run_test(input string name);
        int n;
        test_errors = 0;
        tests++;
        cycle_budget += 20 * plen;
        @(posedge clk);
        rstn <= 1'b0;
        for (int i = 0; i < plen; i++) begin
            imem_we    <= 1'b1;
            imem_addr  <= cpu_pkg::pc_t'(i);
            imem_wdata <= prog[i];
            @(posedge clk);
        end
        imem_we <= 1'b0;
        repeat (4) @(posedge clk);
        run_model();
        got_addr.delete();
        got_data.delete();
        rstn <= 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        // anything behind ret would show up here
        repeat (8) @(negedge clk);
        checks++;
        if (got_addr.size() != exp_addr.size()) begin
            $display("wrong number of stores at %0t: got %0d, expected %0d",
                     $time, got_addr.size(), exp_addr.size());
            errors++;
            test_errors++;
        end
        n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            check_store(got_addr[i], got_data[i], exp_addr[i], exp_data[i]);
        end
        foreach (exp_addr[i]) begin
            check_word(dmem[exp_addr[i]], model_read(exp_addr[i]), exp_addr[i]);
        end
        $display("test %s finished: %0d stores, %0d errors", name, got_addr.size(),
                 test_errors);
    endtask

    // watchdog, 20 cycles for every program word loaded so far
    initial begin
        while (cycles_used <= cycle_budget) begin
            @(posedge clk);
            cycles_used++;
        end
        $display("timeout: the core did not halt within %0d cycles", cycle_budget);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(11874));
        new_program();
        gen_arith(40, 1'b0);
        run_test("arith");
        new_program();
        gen_arith(40, 1'b1);
        run_test("chain");
        new_program();
        gen_branches(16);
        run_test("branch");
        new_program();
        gen_memory(20);
        run_test("memory");
        new_program();
        gen_halt();
        run_test("halt");
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
cpu_pkg.sv
instr_mem.sv
fetch_unit.sv
reg_file.sv
decode_unit.sv
execute_unit.sv
cpu_core_top.sv
cpu_checker.sv
cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module cpu_tb -o cpu_sim

out=$(./obj_dir/cpu_sim || true)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
